/* common/uopPkg.sv */
// Shared types, field positions and opcodes of the micro-op expander, imported by all its modules
package uopPkg;

	typedef logic [31:0] instrT; // Instruction or micro-op word
	typedef logic [15:0] regListT; // LDM/STM register mask
	typedef logic [3:0] regIdxT; // Register index
	typedef logic [3:0] flagsT; // N Z C V from msb down
	typedef logic [4:0] countT; // Up to 16 registers
	typedef logic [3:0] rzCodeT; // Msb steers the RA1 mux, low bits pick Rz on WA3/RA2/RA1

	// Which expansion an incoming word needs
	typedef enum logic [1:0] {
		classPlain,
		classRsr,
		classBl,
		classBlockTransfer
	} instrClassT;

	// Expansion FSM states
	typedef enum logic [2:0] {
		stReady, // First step of any expansion, or pass-through
		stRsr, // Second RSR step
		stBl, // Branch without link
		stLdm, // Remaining loads
		stStm, // Remaining stores
		stWriteback // Base register update
	} seqStateT;

	localparam regIdxT rzIndex = 4'b1111; // Rz scratch register, aliased on R15 code
	localparam regIdxT linkIndex = 4'b1110; // LR

	localparam regIdxT opMov = 4'b1101;
	localparam regIdxT opAdd = 4'b0100;
	localparam regIdxT opSub = 4'b0010;

	localparam regIdxT condAlways = 4'b1110; // AL

	localparam logic [7:0] pcOffset = 8'd4; // Return address is PC - 4 in decode

	// Field positions in the 32-bit word
	localparam int condMsb = 31;
	localparam int condLsb = 28;
	localparam int pPos = 24; // Pre-index
	localparam int uPos = 23; // Up
	localparam int wPos = 21; // Base writeback
	localparam int lPos = 20; // Load
	localparam int rnMsb = 19;
	localparam int rnLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 12;

endpackage

/* rtl/condEval.sv */
// Checks the condition field of the held instruction against the live NZCV flags for the expander
`timescale 1ns/1ps

module condEval import uopPkg::*; (
	input regIdxT cond, // Instruction bits 31:28
	input flagsT flags,
	output logic condPass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[3];
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (cond)
			4'b0000: condPass = z; // EQ
			4'b0001: condPass = ~z; // NE
			4'b0010: condPass = c; // CS
			4'b0011: condPass = ~c; // CC
			4'b0100: condPass = n; // MI
			4'b0101: condPass = ~n; // PL
			4'b0110: condPass = v; // VS
			4'b0111: condPass = ~v; // VC
			4'b1000: condPass = c & ~z; // HI
			4'b1001: condPass = ~c | z; // LS
			4'b1010: condPass = (n == v); // GE
			4'b1011: condPass = (n != v); // LT
			4'b1100: condPass = ~z & (n == v); // GT
			4'b1101: condPass = z | (n != v); // LE
			condAlways: condPass = 1'b1;
			default: condPass = 1'b0; // NV never executes
		endcase
	end

endmodule

/* blockTransfer/regListTracker.sv */
// Walks the LDM/STM register list one register per unstalled step and supplies the start offset
`timescale 1ns/1ps

module regListTracker import uopPkg::*; (
	input logic clk,
	input logic reset,
	input logic stallUop,
	input instrT defaultInstr,
	input seqStateT state,
	output regIdxT nextReg, // Register for this transfer
	output logic [11:0] startOffset, // Offset of the first transfer from Rn
	output logic addUp, // U bit of the first transfer
	output countT listCount, // Registers in the whole mask
	output logic lastReg, // One register left in the working list
	output logic noRegsLeft
);

	regListT remList; // Registers not yet transferred
	regListT workList;
	countT workCount;

	// A new instruction starts from its own mask
	always_comb begin
		if (state == stReady || state == stWriteback)
			workList = defaultInstr[15:0];
		else
			workList = remList;
	end

	// Lowest set bit wins
	always_comb begin
		nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (workList[i])
				nextReg = regIdxT'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			remList <= '0;
		else if (!stallUop)
			remList <= workList & ~(regListT'(1) << nextReg); // Drop the one just issued
	end

	assign workCount = countT'($countones(workList));
	assign lastReg = (workCount == 5'd1);
	assign noRegsLeft = (workCount == 5'd0);
	assign listCount = countT'($countones(defaultInstr[15:0]));

	// Addressing mode from P and U
	always_comb begin
		case ({defaultInstr[pPos], defaultInstr[uPos]})
			2'b00: begin // DA
				startOffset = {5'b0, listCount - 5'd1, 2'b00};
				addUp = 1'b0;
			end
			2'b01: begin // IA
				startOffset = 12'd0;
				addUp = 1'b1;
			end
			2'b10: begin // DB
				startOffset = {5'b0, listCount, 2'b00};
				addUp = 1'b0;
			end
			default: begin // IB
				startOffset = 12'd4;
				addUp = 1'b1;
			end
		endcase
	end

endmodule

/* rtl/instrClassifier.sv */
// Sorts the decoded instruction word into the expansion class that the sequencer acts on
`timescale 1ns/1ps

module instrClassifier import uopPkg::*; (
	input instrT defaultInstr,
	output instrClassT instrClass
);

	logic bxPattern;
	logic isRsr;
	logic isBl;
	logic isBlock;

	// BX and BLX share the RSR bit pattern
	assign bxPattern = (defaultInstr[27:6] == {8'b0001_0010, 12'hFFF, 2'b00});

	// Data processing with a register-specified shift amount
	assign isRsr = (defaultInstr[27:25] == 3'b000)
		& ~defaultInstr[7]
		& defaultInstr[4]
		& ~bxPattern;

	assign isBl = (defaultInstr[27:24] == 4'b1011); // B with L set

	assign isBlock = (defaultInstr[27:25] == 3'b100); // LDM or STM

	always_comb begin
		if (isRsr)
			instrClass = classRsr;
		else if (isBl)
			instrClass = classBl;
		else if (isBlock)
			instrClass = classBlockTransfer;
		else
			instrClass = classPlain;
	end

endmodule

/* rtl/uopSequencer.sv */
// Expansion FSM of the decode stage; holds the state and drives the stall and datapath strobes
`timescale 1ns/1ps

module uopSequencer import uopPkg::*; (
	input logic clk,
	input logic reset,
	input logic stallUop, // Back-pressure from the hazard unit
	input instrClassT instrClass,
	input logic lBit,
	input logic wBit,
	input logic condPass,
	input logic lastReg,
	input logic noRegsLeft,
	output seqStateT state,
	output logic instrMux, // Select micro-op over the raw word
	output logic noFlagUpdate,
	output logic uopStall, // Hold fetch and decode
	output logic blockForward, // Forward Rz address for later transfers
	output logic prevRsr
);

	seqStateT nextState;

	always_ff @(posedge clk) begin
		if (reset)
			state <= stReady;
		else if (!stallUop)
			state <= nextState;
	end

	always_comb begin
		nextState = stReady;
		instrMux = 1'b1;
		noFlagUpdate = 1'b0;
		uopStall = 1'b0;
		blockForward = 1'b0;
		prevRsr = 1'b0;
		case (state)
			stReady: begin
				uopStall = (instrClass != classPlain);
				instrMux = (instrClass != classPlain);
				case (instrClass)
					classRsr: begin
						nextState = stRsr;
						noFlagUpdate = 1'b1; // MOV into Rz must keep the flags
					end
					classBl: nextState = stBl;
					classBlockTransfer: begin
						nextState = lBit ? stLdm : stStm;
						noFlagUpdate = 1'b1;
					end
					default: nextState = stReady;
				endcase
			end
			stRsr: prevRsr = 1'b1; // Real operation with its own S bit
			stBl: nextState = stReady;
			stLdm, stStm: begin
				noFlagUpdate = 1'b1;
				if (!condPass || noRegsLeft) begin
					nextState = stReady; // No-op closes the sequence
				end else if (lastReg) begin
					blockForward = 1'b1;
					uopStall = wBit;
					nextState = wBit ? stWriteback : stReady;
				end else begin
					blockForward = 1'b1;
					uopStall = 1'b1;
					nextState = state;
				end
			end
			stWriteback: noFlagUpdate = 1'b1;
			default: instrMux = 1'b0;
		endcase
	end

endmodule

/* rtl/uopFormer.sv */
// Builds the micro-op word and the regFileRz code for the current expansion step
`timescale 1ns/1ps

module uopFormer import uopPkg::*; (
	input instrT defaultInstr,
	input seqStateT state,
	input instrClassT instrClass,
	input logic condPass,
	input regIdxT nextReg,
	input logic [11:0] startOffset,
	input logic addUp,
	input countT listCount,
	output instrT uopInstr,
	output rzCodeT regFileRz
);

	regIdxT cond;
	regIdxT rn;
	logic load;
	logic listEmpty;

	assign cond = defaultInstr[condMsb:condLsb];
	assign rn = defaultInstr[rnMsb:rnLsb];
	assign load = defaultInstr[lPos];
	// First step already took one register so a single-register list is spent
	assign listEmpty = (listCount < 5'd2);

	// Data processing word, S clear
	function automatic instrT dpWord(input regIdxT cc, input logic imm, input regIdxT opcode,
		input regIdxT rnF, input regIdxT rdF, input logic [11:0] operand);
		instrT w;
		w = '0;
		w[condMsb:condLsb] = cc;
		w[25] = imm;
		w[24:21] = opcode;
		w[rnMsb:rnLsb] = rnF;
		w[rdMsb:rdLsb] = rdF;
		w[11:0] = operand;
		return w;
	endfunction

	// Preindexed single word transfer with immediate offset and no writeback
	function automatic instrT xferWord(input regIdxT cc, input logic ld, input logic up,
		input regIdxT rnF, input regIdxT rdF, input logic [11:0] offset);
		instrT w;
		w = '0;
		w[condMsb:condLsb] = cc;
		w[27:26] = 2'b01;
		w[pPos] = 1'b1;
		w[uPos] = up;
		w[wPos] = 1'b0;
		w[lPos] = ld;
		w[rnMsb:rnLsb] = rnF;
		w[rdMsb:rdLsb] = rdF;
		w[11:0] = offset;
		return w;
	endfunction

	always_comb begin
		uopInstr = defaultInstr; // Pass-through
		regFileRz = 4'b0000;
		case (state)
			stReady: begin
				case (instrClass)
					classRsr: begin
						uopInstr = dpWord(cond, 1'b0, opMov, 4'b0000, rzIndex, defaultInstr[11:0]);
						regFileRz = 4'b1100; // Rz as destination
					end
					classBl: uopInstr = dpWord(cond, 1'b1, opSub, 4'b1111, linkIndex,
						{4'b0000, pcOffset}); // LR = PC - 4
					classBlockTransfer: uopInstr = xferWord(cond, load, addUp, rn, nextReg,
						startOffset);
					default: uopInstr = defaultInstr;
				endcase
			end
			stRsr: begin
				uopInstr = {defaultInstr[31:12], 8'b0, rzIndex}; // Unshifted Rz operand
				regFileRz = 4'b0010;
			end
			stBl: uopInstr = {defaultInstr[31:25], 1'b0, defaultInstr[23:0]}; // Plain branch
			stLdm, stStm: begin
				if (!condPass || listEmpty) begin
					uopInstr = dpWord(cond, 1'b1, opAdd, 4'b0000, 4'b0000, 12'd0); // R0 = R0 + 0
				end else begin
					uopInstr = xferWord(cond, load, 1'b1, rzIndex, nextReg, 12'd4); // Rz + 4
					regFileRz = load ? 4'b0001 : 4'b0000;
				end
			end
			// Rn = Rn +- count * 4 via rotate right by 30
			stWriteback: uopInstr = dpWord(cond, 1'b1, defaultInstr[uPos] ? opAdd : opSub,
				rn, rn, {4'b1111, 3'b000, listCount});
			default: uopInstr = defaultInstr;
		endcase
	end

endmodule

/* rtl/uopExpander.sv */
// Top level of the micro-op expander in the decode stage; connects classifier, FSM and datapath
`timescale 1ns/1ps

module uopExpander import uopPkg::*; (
	input logic clk,
	input logic reset,
	input instrT defaultInstr, // Decoded word, held while uopStall is high
	input flagsT flags,
	input logic stallUop,
	output instrT uopInstr,
	output logic instrMux,
	output logic noFlagUpdate,
	output logic uopStall,
	output logic blockForward,
	output logic prevRsr,
	output rzCodeT regFileRz
);

	instrClassT instrClass;
	seqStateT state;
	logic condPass;
	regIdxT nextReg;
	logic [11:0] startOffset;
	logic addUp;
	countT listCount;
	logic lastReg;
	logic noRegsLeft;

	condEval condEval_inst (
		.cond(defaultInstr[condMsb:condLsb]),
		.flags(flags),
		.condPass(condPass)
	);

	instrClassifier instrClassifier_inst (
		.defaultInstr(defaultInstr),
		.instrClass(instrClass)
	);

	regListTracker regListTracker_inst (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.defaultInstr(defaultInstr),
		.state(state),
		.nextReg(nextReg),
		.startOffset(startOffset),
		.addUp(addUp),
		.listCount(listCount),
		.lastReg(lastReg),
		.noRegsLeft(noRegsLeft)
	);

	uopSequencer uopSequencer_inst (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.instrClass(instrClass),
		.lBit(defaultInstr[lPos]),
		.wBit(defaultInstr[wPos]),
		.condPass(condPass),
		.lastReg(lastReg),
		.noRegsLeft(noRegsLeft),
		.state(state),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.blockForward(blockForward),
		.prevRsr(prevRsr)
	);

	uopFormer uopFormer_inst (
		.defaultInstr(defaultInstr),
		.state(state),
		.instrClass(instrClass),
		.condPass(condPass),
		.nextReg(nextReg),
		.startOffset(startOffset),
		.addUp(addUp),
		.listCount(listCount),
		.uopInstr(uopInstr),
		.regFileRz(regFileRz)
	);

endmodule

/* bench/uopExpander_properties.sv */
// Concurrent assertions on the expander outputs, bound into every uopExpander instance
`timescale 1ns/1ps

module uopExpander_properties import uopPkg::*; (
	input logic clk,
	input logic reset,
	input logic stallUop,
	input instrT uopInstr,
	input logic noFlagUpdate,
	input logic uopStall,
	input logic prevRsr
);

	// No sequence in flight right out of reset
	idleAfterReset: assert property (@(posedge clk) $fell(reset) |-> !uopStall)
		else $error("uopStall high in the first cycle after reset");

	// Rz operand step only right after the flag-preserving MOV into Rz
	rsrFollowsMov: assert property (@(posedge clk) disable iff (reset)
		prevRsr && !$past(stallUop) |-> $past(uopStall && noFlagUpdate))
		else $error("prevRsr high without a preceding MOV into Rz");

	// Back-pressure freezes the issued word
	holdOnBackPressure: assert property (@(posedge clk) disable iff (reset)
		stallUop |=> $stable(uopInstr))
		else $error("uopInstr changed while stallUop was high");

endmodule

bind uopExpander uopExpander_properties uopExpanderProps_inst (
	.clk(clk),
	.reset(reset),
	.stallUop(stallUop),
	.uopInstr(uopInstr),
	.noFlagUpdate(noFlagUpdate),
	.uopStall(uopStall),
	.prevRsr(prevRsr)
);

/* bench/uopExpanderTb.sv */
// Testbench for the micro-op expander; runs a stimulus table through a reference model and checks
`timescale 1ns/1ps

module uopExpanderTb import uopPkg::*; ();

	localparam int numRows = 17;
	localparam int timeoutCycles = numRows * 20 + 50; // Longest row well under 20 cycles

	logic clk;
	logic reset;
	instrT defaultInstr;
	flagsT flags;
	logic stallUop;
	instrT uopInstr;
	logic instrMux;
	logic noFlagUpdate;
	logic uopStall;
	logic blockForward;
	logic prevRsr;
	rzCodeT regFileRz;

	instrT rowInstr [numRows]; // Stimulus table
	flagsT rowFlags [numRows];
	logic rowStall [numRows]; // Stretch step 1 by a 2-cycle stallUop
	int rowLen [numRows]; // Expected unstalled cycles
	int rowFill;
	int passCount;
	int failCount;
	int rowErrors;
	int cycleCount;

	uopExpander uopExpander_inst (
		.clk(clk),
		.reset(reset),
		.defaultInstr(defaultInstr),
		.flags(flags),
		.stallUop(stallUop),
		.uopInstr(uopInstr),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.blockForward(blockForward),
		.prevRsr(prevRsr),
		.regFileRz(regFileRz)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic addRow(input instrT ins, input flagsT fl, input logic st, input int len);
		rowInstr[rowFill] = ins;
		rowFlags[rowFill] = fl;
		rowStall[rowFill] = st;
		rowLen[rowFill] = len;
		rowFill++;
	endtask

	task automatic reportError(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		rowErrors++;
	endtask

	// ARM condition codes over N Z C V, odd codes invert the even one
	function automatic logic condHolds(input logic [3:0] cc, input flagsT fl);
		logic r;
		case (cc[3:1])
			3'd0: r = fl[2]; // EQ
			3'd1: r = fl[1]; // CS
			3'd2: r = fl[3]; // MI
			3'd3: r = fl[0]; // VS
			3'd4: r = fl[1] & !fl[2]; // HI
			3'd5: r = (fl[3] == fl[0]); // GE
			3'd6: r = !fl[2] & (fl[3] == fl[0]); // GT
			default: r = 1'b1; // AL
		endcase
		if (cc == 4'hF)
			r = 1'b0;
		else if (cc[0])
			r = !r;
		return r;
	endfunction

	// Index of the k-th set bit counting up from R0
	function automatic regIdxT nthReg(input logic [15:0] mask, input int k);
		int seen;
		seen = 0;
		for (int i = 0; i < 16; i++) begin
			if (mask[i]) begin
				if (seen == k)
					return regIdxT'(i);
				seen++;
			end
		end
		return 4'h0;
	endfunction

	// Expected outputs for unstalled step s of an instruction
	function automatic void predictStep(input instrT ins, input flagsT fl, input int s,
		output instrT eUop, output logic eStall, output rzCodeT eRz, output logic [3:0] eStrobe);
		int n;
		logic [3:0] cc;
		logic [11:0] off;
		logic up;
		cc = ins[31:28];
		n = $countones(ins[15:0]);
		eUop = ins; // Plain pass-through
		eStall = 1'b0;
		eRz = 4'b0000;
		eStrobe = 4'b0000; // instrMux noFlagUpdate blockForward prevRsr
		if (ins[27:25] == 3'b000 && !ins[7] && ins[4] && !(ins[27:8] == 20'h12FFF && !ins[6])) begin
			eStrobe = (s == 0) ? 4'b1100 : 4'b1001;
			if (s == 0) begin
				eUop = {cc, 3'b000, 4'b1101, 1'b0, 4'h0, 4'hF, ins[11:0]}; // MOV Rz, shifter
				eStall = 1'b1;
				eRz = 4'b1100;
			end else begin
				eUop = {ins[31:12], 8'h00, 4'hF}; // Rz as plain operand
				eRz = 4'b0010;
			end
		end else if (ins[27:24] == 4'b1011) begin
			eStrobe = 4'b1000;
			eStall = (s == 0);
			if (s == 0)
				eUop = {cc, 3'b001, 4'b0010, 1'b0, 4'hF, 4'hE, 12'h004}; // SUB LR, PC, #4
			else
				eUop = ins & ~32'h0100_0000; // Link bit cleared
		end else if (ins[27:25] == 3'b100) begin
			eStrobe = 4'b1100;
			if (s == 0) begin
				case ({ins[24], ins[23]})
					2'b00: off = 12'((n - 1) * 4); // DA
					2'b01: off = 12'd0; // IA
					2'b10: off = 12'(n * 4); // DB
					default: off = 12'd4; // IB
				endcase
				up = ins[23];
				eUop = {cc, 3'b010, 1'b1, up, 2'b00, ins[20], ins[19:16], nthReg(ins[15:0], 0), off};
				eStall = 1'b1;
			end else if (!condHolds(cc, fl) || n < 2) begin
				eUop = {cc, 3'b001, 4'b0100, 1'b0, 8'h00, 12'h000}; // ADD R0, R0, #0
			end else if (s < n) begin
				eUop = {cc, 3'b010, 2'b11, 2'b00, ins[20], 4'hF, nthReg(ins[15:0], s), 12'd4};
				eStall = (s < n - 1) || ins[21];
				eRz = {3'b000, ins[20]};
				eStrobe = 4'b1110;
			end else begin
				eUop = {cc, 3'b001, ins[23] ? 4'b0100 : 4'b0010, 1'b0, ins[19:16], ins[19:16],
					4'hF, 8'(n)}; // n ROR 30 gives 4n
			end
		end
	endfunction

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, a sequence never finished", cycleCount);
		$display("sim failed");
		$finish;
	end

	initial begin
		int r;
		int step;
		int holdLeft;
		logic done;
		instrT ins;
		flagsT fl;
		instrT expUop;
		logic expStall;
		rzCodeT expRz;
		logic [3:0] expStrobe;
		reset = 1'b1;
		defaultInstr = '0;
		flags = '0;
		stallUop = 1'b0;
		rowFill = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(81257));
		addRow(32'hE281_1001, 4'h0, 1'b0, 1); // ADD immediate
		addRow(32'hE1A0_0001, 4'h0, 1'b0, 1); // MOV register
		addRow(32'hE083_2514, 4'h0, 1'b0, 2); // ADD LSL by register
		addRow(32'hE093_2634, 4'h0, 1'b1, 2); // ADDS LSR by register, stalled
		addRow(32'hEB00_0010, 4'h0, 1'b0, 2); // BL
		addRow(32'h1B00_FF00, 4'h0, 1'b1, 2); // BLNE, stalled
		addRow(32'hE8B1_0094, 4'h0, 1'b0, 4); // LDMIA R1!
		addRow(32'hE92D_4070, 4'h0, 1'b1, 5); // STMDB SP!, stalled
		addRow(32'hE993_0003, 4'h0, 1'b0, 2); // LDMIB R3
		addRow(32'hE805_8302, 4'h0, 1'b0, 4); // STMDA R5
		addRow(32'hE890_0168, 4'h0, 1'b0, 4); // LDMIA R0
		addRow(32'hE832_0006, 4'h0, 1'b1, 3); // LDMDA R2!, stalled
		addRow(32'hE914_0C00, 4'h0, 1'b0, 2); // LDMDB R4
		addRow(32'hE9A6_000C, 4'h0, 1'b0, 3); // STMIB R6!
		addRow(32'hE8B2_0020, 4'h0, 1'b0, 2); // Single register
		addRow(32'h0891_000E, 4'h0, 1'b0, 2); // LDMEQ with Z clear
		addRow(32'h18A4_0201, 4'h0, 1'b0, 3); // STMNE with Z clear
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (r = 0; r < numRows; r++) begin
			ins = rowInstr[r];
			fl = rowFlags[r];
			if (ins[27:25] == 3'b001) begin
				ins[11:0] = 12'($urandom); // Immediate operand
			end else if (ins[27:24] == 4'b1011) begin
				ins[23:0] = 24'($urandom); // Branch offset
			end else if (ins[27:25] == 3'b000) begin
				ins[15:12] = 4'($urandom); // Rd
				ins[3:0] = 4'($urandom); // Rm
			end
			if (ins[31:28] == condAlways)
				fl = 4'($urandom);
			step = 0;
			holdLeft = 0;
			rowErrors = 0;
			done = 1'b0;
			@(posedge clk);
			defaultInstr <= ins;
			flags <= fl;
			stallUop <= 1'b0;
			while (!done) begin
				@(negedge clk);
				predictStep(ins, fl, step, expUop, expStall, expRz, expStrobe);
				if (uopInstr !== expUop)
					reportError("uopInstr", expUop, uopInstr);
				if (uopStall !== expStall)
					reportError("uopStall", 32'(expStall), 32'(uopStall));
				if (regFileRz !== expRz)
					reportError("regFileRz", 32'(expRz), 32'(regFileRz));
				if ({instrMux, noFlagUpdate, blockForward, prevRsr} !== expStrobe)
					reportError("{instrMux,noFlagUpdate,blockForward,prevRsr}", 32'(expStrobe),
						32'({instrMux, noFlagUpdate, blockForward, prevRsr}));
				if (stallUop) begin
					holdLeft--; // Frozen step, same outputs expected again
				end else if (!uopStall) begin
					done = 1'b1;
				end else begin
					step++;
					if (rowStall[r] && step == 1)
						holdLeft = 2;
				end
				if (!done) begin
					@(posedge clk);
					stallUop <= (holdLeft > 0);
				end
			end
			if (step + 1 != rowLen[r])
				reportError("sequence length", 32'(rowLen[r]), 32'(step + 1));
			if (rowErrors == 0)
				passCount++;
			else
				failCount++;
			$display("Test %0d instr %h %s after %0d steps", r, ins,
				(rowErrors == 0) ? "PASS" : "FAIL", step + 1);
		end
		$display("Tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* sources.f */
common/uopPkg.sv
rtl/condEval.sv
blockTransfer/regListTracker.sv
rtl/instrClassifier.sv
rtl/uopSequencer.sv
rtl/uopFormer.sv
rtl/uopExpander.sv
bench/uopExpander_properties.sv
bench/uopExpanderTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module uopExpanderTb \
	-f sources.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/VuopExpanderTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
exit 1
